/* hdl/mmio_cpl_pkg.sv */
//########################################
// Widths, TLP format/type codes and CplD
// header field positions for MMIO reads
//########################################
package mmio_cpl_pkg;

    // Requester and completer IDs share one width
    localparam int REQ_ID_BITS = 16;
    localparam int ADDR_LO_BITS = 7;
    localparam int LEN_DW_BITS = 10;
    localparam int BYTE_CNT_BITS = 12;

    // Tag field as it appears on the host channel and in the header
    localparam int TAG_FIELD_BITS = 8;

    // Each output channel carries half of the widest response
    localparam int CH_PAYLOAD_BITS = 256;
    localparam int PAYLOAD_BITS = 512;
    localparam int HDR_BITS = 96;

    // Largest read accepted, and largest completion that fits in channel 0
    localparam int MAX_LEN_DW = 16;
    localparam int SINGLE_CH_BYTES = 32;

    typedef enum logic [7:0] {
        FMT_MRD32 = 8'h00,
        FMT_MRD64 = 8'h20,
        FMT_CPLD  = 8'h4A
    } tlp_fmttype_e;

    // Low bit of each field in the three-dword CplD header
    localparam int HDR_FMTTYPE_LSB = 88;
    localparam int HDR_LENGTH_LSB = 64;
    localparam int HDR_CPL_ID_LSB = 48;
    localparam int HDR_BYTE_CNT_LSB = 32;
    localparam int HDR_REQ_ID_LSB = 16;
    localparam int HDR_TAG_LSB = 8;
    localparam int HDR_ADDR_LO_LSB = 0;

    // Meta word per tag is {tag, requester ID, lower address, byte count}
    function automatic int meta_bits(input int tag_bits);
        return tag_bits + REQ_ID_BITS + ADDR_LO_BITS + BYTE_CNT_BITS;
    endfunction

endpackage

/* hdl/mmio_rd_req_decode.sv */
//########################################
// MMIO read request decoder with sticky
// error for unsupported requests
//########################################
`timescale 1ns/1ps

module mmio_rd_req_decode
    import mmio_cpl_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      req_valid,
    input  tlp_fmttype_e              req_fmttype,
    input  logic [TAG_FIELD_BITS-1:0] req_tag,
    input  logic [REQ_ID_BITS-1:0]    req_requester_id,
    input  logic [ADDR_LO_BITS-1:0]   req_addr_lo,
    input  logic [LEN_DW_BITS-1:0]    req_length_dw,
    output logic                      meta_valid,
    output logic [TAG_FIELD_BITS-1:0] meta_tag,
    output logic [REQ_ID_BITS-1:0]    meta_requester_id,
    output logic [ADDR_LO_BITS-1:0]   meta_addr_lo,
    output logic [BYTE_CNT_BITS-1:0]  meta_byte_count,
    output logic                      error
);

    logic is_read;
    logic len_ok;
    logic supported;

    // Only 32 and 64 bit memory reads are completed here
    assign is_read = (req_fmttype == FMT_MRD32) || (req_fmttype == FMT_MRD64);
    // A zero length field would mean 1024 dwords, far beyond the widest response
    assign len_ok = (req_length_dw != '0) && (req_length_dw <= LEN_DW_BITS'(MAX_LEN_DW));
    assign supported = is_read && len_ok;

    always_ff @(posedge clk)
    begin
        meta_valid <= req_valid && supported;
        meta_tag <= req_tag;
        meta_requester_id <= req_requester_id;
        // All byte enables are set, so the first byte is dword aligned
        meta_addr_lo <= {req_addr_lo[ADDR_LO_BITS-1:2], 2'b00};
        meta_byte_count <= {req_length_dw, 2'b00};

        // Stays set until the next reset
        if (req_valid && !supported)
        begin
            error <= 1'b1;
        end

        if (!reset_n)
        begin
            meta_valid <= 1'b0;
            error <= 1'b0;
        end
    end

    // The request that trips the error must not also reach the tag table
    assert property (@(posedge clk) disable iff (!reset_n) $rose(error) |-> !meta_valid)
        else $error("Unsupported MMIO read produced a table entry");

endmodule

/* hdl/tag_meta_ram.sv */
//########################################
// Per-tag request field table, registered
// write and combinational read
//########################################
`timescale 1ns/1ps

module tag_meta_ram
#(
    parameter int N_ENTRIES = 32,
    parameter int N_DATA_BITS = 64
)
(
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic [$clog2(N_ENTRIES)-1:0] waddr,
    input  logic                         wen,
    input  logic [N_DATA_BITS-1:0]       wdata,
    input  logic [$clog2(N_ENTRIES)-1:0] raddr,
    output logic [N_DATA_BITS-1:0]       rdata
);

    // Small enough to map onto LUT RAM
    logic [N_DATA_BITS-1:0] mem [N_ENTRIES];

    // Writes are ignored while the path is held in reset
    always_ff @(posedge clk)
    begin
        if (wen && reset_n)
        begin
            mem[waddr] <= wdata;
        end
    end

    // Response tag looks up its fields in the same cycle it arrives
    assign rdata = mem[raddr];

endmodule

/* hdl/cpl_skid_fifo2.sv */
//########################################
// Two-entry FIFO with registered not_full
//########################################
`timescale 1ns/1ps

module cpl_skid_fifo2
#(
    parameter int N_DATA_BITS = 32
)
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic [N_DATA_BITS-1:0] enq_data,
    input  logic                   enq_en,
    input  logic                   deq_en,
    output logic [N_DATA_BITS-1:0] first,
    output logic                   not_full,
    output logic                   not_empty
);

    // Entry 0 is always the head, entry 1 is only used when both are occupied
    logic [N_DATA_BITS-1:0] entry0;
    logic [N_DATA_BITS-1:0] entry1;
    logic [1:0] count;
    logic [1:0] count_next;
    logic enq_to_head;

    assign count_next = count + 2'(enq_en) - 2'(deq_en);

    // New data lands in the head slot whenever the head will be free after this edge
    assign enq_to_head = deq_en ? (count != 2'd2) : (count == 2'd0);

    always_ff @(posedge clk)
    begin
        if (deq_en && (count == 2'd2))
        begin
            entry0 <= entry1;
        end

        if (enq_en && enq_to_head)
        begin
            entry0 <= enq_data;
        end

        if (enq_en && !enq_to_head)
        begin
            entry1 <= enq_data;
        end
    end

    always_ff @(posedge clk)
    begin
        count <= count_next;
        // Registered so upstream ready has no combinational path from deq_en
        not_full <= (count_next != 2'd2);

        if (!reset_n)
        begin
            count <= 2'd0;
            not_full <= 1'b1;
        end
    end

    assign first = entry0;
    assign not_empty = (count != 2'd0);

    assert property (@(posedge clk) disable iff (!reset_n) enq_en |-> not_full)
        else $error("Enqueue into full completion FIFO");
    assert property (@(posedge clk) disable iff (!reset_n) deq_en |-> not_empty)
        else $error("Dequeue from empty completion FIFO");

endmodule

/* hdl/mmio_cpl_gen.sv */
//########################################
// CplD generator joining AFU read data
// with stored request fields per tag
//########################################
`timescale 1ns/1ps

module mmio_cpl_gen
    import mmio_cpl_pkg::*;
#(
    parameter int MAX_OUTSTANDING = 32
)
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      meta_valid,
    input  logic [TAG_FIELD_BITS-1:0] meta_tag,
    input  logic [REQ_ID_BITS-1:0]    meta_requester_id,
    input  logic [ADDR_LO_BITS-1:0]   meta_addr_lo,
    input  logic [BYTE_CNT_BITS-1:0]  meta_byte_count,
    input  logic                      rsp_valid,
    output logic                      rsp_ready,
    input  logic [TAG_FIELD_BITS-1:0] rsp_tag,
    input  logic [PAYLOAD_BITS-1:0]   rsp_payload,
    output logic                      tx_valid,
    input  logic                      tx_ready,
    output logic                      tx_last,
    output logic [1:0]                tx_ch_valid,
    output logic [1:0]                tx_ch_sop,
    output logic [1:0]                tx_ch_eop,
    output logic [HDR_BITS-1:0]       tx_hdr,
    output logic [PAYLOAD_BITS-1:0]   tx_payload
);

    localparam int TAG_BITS = $clog2(MAX_OUTSTANDING);
    localparam int META_BITS = meta_bits(TAG_BITS);

    logic meta_valid_q;
    logic [META_BITS-1:0] meta_word_q;
    logic [TAG_BITS-1:0] wr_idx;
    logic [TAG_BITS-1:0] rsp_idx;
    logic [META_BITS-1:0] rsp_meta;
    logic rsp_xfer;
    logic [PAYLOAD_BITS+META_BITS-1:0] head;
    logic head_valid;
    logic head_deq;
    logic [PAYLOAD_BITS-1:0] head_payload;
    logic [TAG_BITS-1:0] head_tag;
    logic [REQ_ID_BITS-1:0] head_req_id;
    logic [ADDR_LO_BITS-1:0] head_addr_lo;
    logic [BYTE_CNT_BITS-1:0] head_byte_cnt;
    logic [HDR_BITS-1:0] cpl_hdr;
    logic dual_ch;
    logic tx_free;
    logic [MAX_OUTSTANDING-1:0] tag_active;

    // One more register stage before the table write, as on the host side
    always_ff @(posedge clk)
    begin
        meta_valid_q <= meta_valid;
        meta_word_q <= {meta_tag[TAG_BITS-1:0], meta_requester_id, meta_addr_lo,
                        meta_byte_count};

        if (!reset_n)
        begin
            meta_valid_q <= 1'b0;
        end
    end

    assign wr_idx = meta_word_q[META_BITS-1 -: TAG_BITS];
    assign rsp_idx = rsp_tag[TAG_BITS-1:0];
    assign rsp_xfer = rsp_valid && rsp_ready;

    tag_meta_ram #(
        .N_ENTRIES(MAX_OUTSTANDING),
        .N_DATA_BITS(META_BITS)
    ) meta_ram_i (
        .clk(clk),
        .reset_n(reset_n),
        .waddr(wr_idx),
        .wen(meta_valid_q),
        .wdata(meta_word_q),
        .raddr(rsp_idx),
        .rdata(rsp_meta)
    );

    // Each accepted response is queued together with its request fields
    cpl_skid_fifo2 #(
        .N_DATA_BITS(PAYLOAD_BITS + META_BITS)
    ) rsp_fifo_i (
        .clk(clk),
        .reset_n(reset_n),
        .enq_data({rsp_payload, rsp_meta}),
        .enq_en(rsp_xfer),
        .deq_en(head_deq),
        .first(head),
        .not_full(rsp_ready),
        .not_empty(head_valid)
    );

    assign {head_payload, head_tag, head_req_id, head_addr_lo, head_byte_cnt} = head;

    // Completer ID stays zero, every other unnamed bit too
    always_comb
    begin
        cpl_hdr = '0;
        cpl_hdr[HDR_FMTTYPE_LSB +: 8] = FMT_CPLD;
        cpl_hdr[HDR_LENGTH_LSB +: LEN_DW_BITS] = LEN_DW_BITS'(head_byte_cnt >> 2);
        cpl_hdr[HDR_CPL_ID_LSB +: REQ_ID_BITS] = '0;
        cpl_hdr[HDR_BYTE_CNT_LSB +: BYTE_CNT_BITS] = head_byte_cnt;
        cpl_hdr[HDR_REQ_ID_LSB +: REQ_ID_BITS] = head_req_id;
        cpl_hdr[HDR_TAG_LSB +: TAG_FIELD_BITS] = TAG_FIELD_BITS'(head_tag);
        cpl_hdr[HDR_ADDR_LO_LSB +: ADDR_LO_BITS] = head_addr_lo;
    end

    // Anything wider than one channel spills into channel 1
    assign dual_ch = (head_byte_cnt > BYTE_CNT_BITS'(SINGLE_CH_BYTES));

    // Output register loads when empty or when its beat is taken
    assign tx_free = tx_ready || !tx_valid;
    assign head_deq = head_valid && tx_free;

    always_ff @(posedge clk)
    begin
        if (tx_free)
        begin
            tx_valid <= head_valid;
            tx_last <= head_valid;
            tx_ch_valid <= {head_valid && dual_ch, head_valid};
            tx_ch_sop <= {1'b0, head_valid};
            tx_ch_eop <= {head_valid && dual_ch, head_valid && !dual_ch};
            tx_hdr <= cpl_hdr;
            // Channel 1 payload is zero on a single-channel completion
            tx_payload <= dual_ch ? head_payload :
                          {{CH_PAYLOAD_BITS{1'b0}}, head_payload[CH_PAYLOAD_BITS-1:0]};
        end

        if (!reset_n)
        begin
            tx_valid <= 1'b0;
            tx_last <= 1'b0;
            tx_ch_valid <= 2'b00;
            tx_ch_sop <= 2'b00;
            tx_ch_eop <= 2'b00;
        end
    end

    // Outstanding tags, kept only for the protocol checks below
    always_ff @(posedge clk)
    begin
        if (rsp_xfer)
        begin
            tag_active[rsp_idx] <= 1'b0;
        end

        if (meta_valid_q)
        begin
            tag_active[wr_idx] <= 1'b1;
        end

        if (!reset_n)
        begin
            tag_active <= '0;
        end
    end

    assert property (@(posedge clk) disable iff (!reset_n)
                     meta_valid |-> (meta_tag < TAG_FIELD_BITS'(MAX_OUTSTANDING)))
        else $error("MMIO read tag 0x%0h outside the tag table", meta_tag);
    assert property (@(posedge clk) disable iff (!reset_n) meta_valid_q |-> !tag_active[wr_idx])
        else $error("Duplicate MMIO read tag 0x%0h", wr_idx);
    assert property (@(posedge clk) disable iff (!reset_n) rsp_xfer |-> tag_active[rsp_idx])
        else $error("Response for inactive MMIO read tag 0x%0h", rsp_idx);

endmodule

/* hdl/mmio_rsp_path.sv */
//########################################
// MMIO read completion path top level
//########################################
`timescale 1ns/1ps

module mmio_rsp_path
    import mmio_cpl_pkg::*;
#(
    parameter int MAX_OUTSTANDING = 32
)
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      req_valid,
    input  tlp_fmttype_e              req_fmttype,
    input  logic [TAG_FIELD_BITS-1:0] req_tag,
    input  logic [REQ_ID_BITS-1:0]    req_requester_id,
    input  logic [ADDR_LO_BITS-1:0]   req_addr_lo,
    input  logic [LEN_DW_BITS-1:0]    req_length_dw,
    input  logic                      rsp_valid,
    output logic                      rsp_ready,
    input  logic [TAG_FIELD_BITS-1:0] rsp_tag,
    input  logic [PAYLOAD_BITS-1:0]   rsp_payload,
    output logic                      tx_valid,
    input  logic                      tx_ready,
    output logic                      tx_last,
    output logic [1:0]                tx_ch_valid,
    output logic [1:0]                tx_ch_sop,
    output logic [1:0]                tx_ch_eop,
    output logic [HDR_BITS-1:0]       tx_hdr,
    output logic [PAYLOAD_BITS-1:0]   tx_payload,
    output logic                      error
);

    // Decoded request fields on their way to the tag table
    logic meta_valid;
    logic [TAG_FIELD_BITS-1:0] meta_tag;
    logic [REQ_ID_BITS-1:0] meta_requester_id;
    logic [ADDR_LO_BITS-1:0] meta_addr_lo;
    logic [BYTE_CNT_BITS-1:0] meta_byte_count;

    mmio_rd_req_decode decode_i (
        .clk(clk),
        .reset_n(reset_n),
        .req_valid(req_valid),
        .req_fmttype(req_fmttype),
        .req_tag(req_tag),
        .req_requester_id(req_requester_id),
        .req_addr_lo(req_addr_lo),
        .req_length_dw(req_length_dw),
        .meta_valid(meta_valid),
        .meta_tag(meta_tag),
        .meta_requester_id(meta_requester_id),
        .meta_addr_lo(meta_addr_lo),
        .meta_byte_count(meta_byte_count),
        .error(error)
    );

    mmio_cpl_gen #(
        .MAX_OUTSTANDING(MAX_OUTSTANDING)
    ) cpl_gen_i (
        .clk(clk),
        .reset_n(reset_n),
        .meta_valid(meta_valid),
        .meta_tag(meta_tag),
        .meta_requester_id(meta_requester_id),
        .meta_addr_lo(meta_addr_lo),
        .meta_byte_count(meta_byte_count),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready),
        .rsp_tag(rsp_tag),
        .rsp_payload(rsp_payload),
        .tx_valid(tx_valid),
        .tx_ready(tx_ready),
        .tx_last(tx_last),
        .tx_ch_valid(tx_ch_valid),
        .tx_ch_sop(tx_ch_sop),
        .tx_ch_eop(tx_ch_eop),
        .tx_hdr(tx_hdr),
        .tx_payload(tx_payload)
    );

endmodule

/* verification/mmio_rsp_path_tb.sv */
//########################################
// Testbench for the MMIO read completion
// path, replaying requests from test data
//########################################
`timescale 1ns/1ps

module mmio_rsp_path_tb
    import mmio_cpl_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int N_ROWS = 16;
    localparam int N_COLS = 8;

    logic clk;
    logic reset_n;
    logic req_valid;
    tlp_fmttype_e req_fmttype;
    logic [7:0] req_tag;
    logic [15:0] req_requester_id;
    logic [6:0] req_addr_lo;
    logic [9:0] req_length_dw;
    logic rsp_valid;
    logic rsp_ready;
    logic [7:0] rsp_tag;
    logic [511:0] rsp_payload;
    logic tx_valid;
    logic tx_ready;
    logic tx_last;
    logic [1:0] tx_ch_valid;
    logic [1:0] tx_ch_sop;
    logic [1:0] tx_ch_eop;
    logic [95:0] tx_hdr;
    logic [511:0] tx_payload;
    logic error;

    // One row per request, columns as described at the top of the data file
    logic [15:0] td [N_ROWS*N_COLS];
    int exp_q[$];
    int cpl_count;
    logic [31:0] drv_seed;
    logic [31:0] chk_seed;

    mmio_rsp_path #(
        .MAX_OUTSTANDING(32)
    ) mmio_rsp_path_i (
        .clk(clk),
        .reset_n(reset_n),
        .req_valid(req_valid),
        .req_fmttype(req_fmttype),
        .req_tag(req_tag),
        .req_requester_id(req_requester_id),
        .req_addr_lo(req_addr_lo),
        .req_length_dw(req_length_dw),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready),
        .rsp_tag(rsp_tag),
        .rsp_payload(rsp_payload),
        .tx_valid(tx_valid),
        .tx_ready(tx_ready),
        .tx_last(tx_last),
        .tx_ch_valid(tx_ch_valid),
        .tx_ch_sop(tx_ch_sop),
        .tx_ch_eop(tx_ch_eop),
        .tx_hdr(tx_hdr),
        .tx_payload(tx_payload),
        .error(error)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check(input string name, input logic [511:0] expected,
                         input logic [511:0] actual);
        if (expected !== actual)
        begin
            abort_run($sformatf("Mismatch %s: expected %0h, actual %0h", name, expected,
                                actual));
        end
    endtask

    // Numerical Recipes constants, one step per 32-bit payload word
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Header as laid out in the CplD format, built from the request row
    function automatic logic [95:0] expected_hdr(input int row);
        logic [95:0] h;
        logic [9:0] len;
        len = td[row*N_COLS+4][9:0];
        h = '0;
        h[95:88] = 8'h4A;
        h[73:64] = len;
        h[43:32] = {len, 2'b00};
        h[31:16] = td[row*N_COLS+2];
        h[15:8] = td[row*N_COLS+1][7:0];
        // Full dword reads start on a dword boundary
        h[6:0] = {td[row*N_COLS+3][6:2], 2'b00};
        return h;
    endfunction

    // Each beat must belong to the oldest response not yet completed
    task automatic check_completion();
        int row;
        int k;
        logic [511:0] exp_data;
        bit dual;
        if (exp_q.size() == 0)
        begin
            abort_run("Completion seen with no outstanding request");
        end
        else
        begin
            row = exp_q.pop_front();
            for (k = 0; k < 16; k++)
            begin
                chk_seed = lcg_next(chk_seed);
                exp_data[k*32 +: 32] = chk_seed;
            end
            // More than eight dwords spill over into channel 1
            dual = (td[row*N_COLS+4] > 16'd8);
            if (!dual)
            begin
                exp_data[511:256] = '0;
            end
            check($sformatf("hdr_row%0d", row), expected_hdr(row), tx_hdr);
            check($sformatf("last_row%0d", row), 1, tx_last);
            check($sformatf("ch_valid_row%0d", row), {dual, 1'b1}, tx_ch_valid);
            check($sformatf("ch_sop_row%0d", row), 2'b01, tx_ch_sop);
            check($sformatf("ch_eop_row%0d", row), dual ? 2'b10 : 2'b01, tx_ch_eop);
            check($sformatf("payload_row%0d", row), exp_data, tx_payload);
            cpl_count++;
        end
    endtask

    // Outputs and tx_ready are both stable half a cycle after the drive point
    always @(negedge clk)
    begin
        if (reset_n && tx_valid && tx_ready)
        begin
            check_completion();
        end
    end

    // Called at the drive point, returns at the drive point after the beat is taken
    task automatic issue_rsp(input int row, input bit check_latency);
        logic [511:0] data;
        int k;
        for (k = 0; k < 16; k++)
        begin
            drv_seed = lcg_next(drv_seed);
            data[k*32 +: 32] = drv_seed;
        end
        rsp_valid = 1'b1;
        rsp_tag = td[row*N_COLS+1][7:0];
        rsp_payload = data;
        exp_q.push_back(row);
        // rsp_ready is registered, so its value now holds through the next edge
        while (!rsp_ready)
        begin
            @(posedge clk);
            #10;
        end
        @(posedge clk);
        #10;
        rsp_valid = 1'b0;
        if (check_latency)
        begin
            // Data reaches the output register one edge after the FIFO takes it
            check("tx_valid_at_accept", 0, tx_valid);
            @(posedge clk);
            #10;
            check("tx_valid_next_edge", 1, tx_valid);
        end
    endtask

    // Three stalled responses fill the output register and both FIFO entries
    task automatic release_backpressure(input int group_len);
        if (group_len >= 3)
        begin
            check("bp_rsp_ready", 0, rsp_ready);
        end
        tx_ready = 1'b1;
    endtask

    initial
    begin
        #(CLK_PERIOD * (N_ROWS * 40 + 4));
        abort_run("Watchdog timeout, completions did not arrive in time");
    end

    initial
    begin
        int i;
        int s;
        int n;
        int row;
        int bp_len;
        bit in_bp;
        bit exp_err;
        int rsp_order[$];
        reset_n = 1'b0;
        req_valid = 1'b0;
        req_fmttype = FMT_MRD32;
        req_tag = '0;
        req_requester_id = '0;
        req_addr_lo = '0;
        req_length_dw = '0;
        rsp_valid = 1'b0;
        rsp_tag = '0;
        rsp_payload = '0;
        tx_ready = 1'b1;
        cpl_count = 0;
        drv_seed = 32'he808_8747;
        chk_seed = 32'he808_8747;
        exp_err = 1'b0;
        in_bp = 1'b0;
        bp_len = 0;
        $readmemh("verification/mmio_testdata.txt", td);

        repeat (2) @(posedge clk);
        #10;
        reset_n = 1'b1;
        check("reset_tx_valid", 0, tx_valid);
        check("reset_error", 0, error);
        check("reset_rsp_ready", 1, rsp_ready);

        // All requests go out back to back, error rises after the bad one is taken
        for (i = 0; i < N_ROWS; i++)
        begin
            req_valid = 1'b1;
            req_fmttype = tlp_fmttype_e'(td[i*N_COLS][7:0]);
            req_tag = td[i*N_COLS+1][7:0];
            req_requester_id = td[i*N_COLS+2];
            req_addr_lo = td[i*N_COLS+3][6:0];
            req_length_dw = td[i*N_COLS+4][9:0];
            @(posedge clk);
            #10;
            exp_err = exp_err | td[i*N_COLS+7][0];
            check($sformatf("error_row%0d", i), exp_err, error);
        end
        req_valid = 1'b0;
        // Leave time for the tag table write before the first response
        repeat (4) @(posedge clk);
        #10;

        // Response order comes from the slot column, rejected requests get none
        for (s = 0; s < N_ROWS; s++)
        begin
            for (i = 0; i < N_ROWS; i++)
            begin
                if (td[i*N_COLS+7] == 16'd0 && td[i*N_COLS+5] == 16'(s))
                begin
                    rsp_order.push_back(i);
                end
            end
        end

        for (n = 0; n < rsp_order.size(); n++)
        begin
            row = rsp_order[n];
            if (td[row*N_COLS+6][0] && !in_bp)
            begin
                // Start a stall only with the output empty
                while (exp_q.size() != 0)
                begin
                    @(posedge clk);
                    #10;
                end
                tx_ready = 1'b0;
                bp_len = 0;
                in_bp = 1'b1;
            end
            if (!td[row*N_COLS+6][0] && in_bp)
            begin
                release_backpressure(bp_len);
                in_bp = 1'b0;
            end
            issue_rsp(row, n == 0);
            if (in_bp)
            begin
                bp_len++;
            end
        end
        if (in_bp)
        begin
            release_backpressure(bp_len);
        end

        while (exp_q.size() != 0)
        begin
            @(posedge clk);
            #10;
        end
        repeat (4) @(posedge clk);
        #10;
        check("error_sticky", exp_err, error);
        if (cpl_count == rsp_order.size() && !tx_valid)
        begin
            $display("sim passed");
            $finish;
        end
        else
        begin
            abort_run("Completion count differs from the number of responses sent");
        end
    end

endmodule

/* compile.f */
hdl/mmio_cpl_pkg.sv
hdl/mmio_rd_req_decode.sv
hdl/tag_meta_ram.sv
hdl/cpl_skid_fifo2.sv
hdl/mmio_cpl_gen.sv
hdl/mmio_rsp_path.sv
verification/mmio_rsp_path_tb.sv

/* verification/mmio_testdata.txt */
// Columns: fmttype tag requester_id addr_lo length_dw rsp_slot backpressure error
// rsp_slot orders the responses, ff marks a request that gets no response
0000 0000 0100 0004 0001 0003 0000 0000
0020 0001 0101 0008 0008 0000 0000 0000
0000 0002 0102 001C 0010 0001 0000 0000
// Memory write code is not a read
0040 0003 0103 0000 0004 00FF 0000 0001
0000 0004 0104 0010 0009 0002 0000 0000
0020 0005 0105 0024 0002 0005 0000 0000
// Zero length field
0000 0006 0106 0000 0000 00FF 0000 0001
0000 0007 0107 003C 000C 0004 0000 0000
// Seventeen dwords is one too many
0000 0008 0108 0044 0011 00FF 0000 0001
// These three are answered while the output is stalled
0020 0009 0109 0050 0001 0006 0001 0000
0000 000A 010A 0054 000F 0007 0001 0000
0000 000B 010B 0058 0005 0008 0001 0000
// A completion code arriving as a request
004A 000C 010C 005C 0004 00FF 0000 0001
0000 001F 1234 007F 0003 0009 0000 0000
0020 0010 ABCD 0060 000D 000B 0000 0000
0000 0011 FFFF 0064 0006 000A 0000 0000
